/* Makefile */
VERILATOR ?= verilator
TOP       ?= hazardUnitTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard src/*.sv src/*.svh test/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* src/hazardPkg.sv */
`include "hazard_config.svh"

package hazardPkg;

    // Major opcode, instruction bits 15 to 11
    // Branches sit in 011xx and are resolved outside this unit
    typedef enum logic [4:0] {
        NOP  = 5'b00001,
        J    = 5'b00100,
        JR   = 5'b00101,
        JAL  = 5'b00110,
        JALR = 5'b00111
    } opcodeT;

    // Destination record for register RAW checks
    typedef struct packed {
        logic [`REG_W-1:0] rd;
        logic              wr;  // Instruction writes rd
    } regTagT;

    // Memory access record for memory RAW checks
    typedef struct packed {
        logic [`INSTR_W-1:0] addr;  // Effective address
        logic                en;    // Instruction accesses memory
    } memTagT;

    // Jump controller state
    typedef enum logic {
        IDLE,
        HOLD   // Jump already stalled, waiting for a new instruction
    } jumpStateT;

endpackage

/* src/hazardUnit.sv */
`timescale 1ns/1ps
`include "hazard_config.svh"

// Hazard detection unit of the five-stage pipeline
module hazardUnit import hazardPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [`INSTR_W-1:0]     instr,
    input  logic [`REG_W-1:0]       rd,
    input  logic                    regWrite,
    input  logic                    memEnable,
    input  logic [`INSTR_W-1:0]     reg1Data,
    input  logic [`INSTR_W-1:0]     imm,
    input  logic                    branchTaken,
    output logic                    nop,
    output logic                    pcStall,
    output logic [3:0]              forwards,
    output logic [`STALL_CNT_W-1:0] stallCount
);

    logic   link;
    logic   rsOnly;
    logic   regHaz;
    logic   memHaz;
    regTagT regIns;
    memTagT memIns;
    regTagT regStages [4];  // ID, EX, MEM, WB
    memTagT memStages [4];

    stageTrack #(.tagT(regTagT)) regTrack (
        .clk    (clk),
        .rstN   (rstN),
        .insTag (regIns),
        .bubble (nop),
        .flush  (branchTaken),
        .stages (regStages)
    );

    stageTrack #(.tagT(memTagT)) memTrack (
        .clk    (clk),
        .rstN   (rstN),
        .insTag (memIns),
        .bubble (nop),
        .flush  (branchTaken),
        .stages (memStages)
    );

    regHazardCheck regCheck (
        .instr       (instr),
        .rd          (rd),
        .regWrite    (regWrite),
        .link        (link),
        .rsOnly      (rsOnly),
        .branchTaken (branchTaken),
        .regStages   (regStages),
        .regIns      (regIns),
        .regHaz      (regHaz),
        .forwards    (forwards)
    );

    memHazardCheck memCheck (
        .reg1Data    (reg1Data),
        .imm         (imm),
        .memEnable   (memEnable),
        .branchTaken (branchTaken),
        .memStages   (memStages),
        .memIns      (memIns),
        .memHaz      (memHaz)
    );

    jumpControl jumpCtrl (
        .clk     (clk),
        .rstN    (rstN),
        .instr   (instr),
        .regHaz  (regHaz),
        .memHaz  (memHaz),
        .link    (link),
        .rsOnly  (rsOnly),
        .nop     (nop),
        .pcStall (pcStall)
    );

    stallTimer stallCnt (
        .clk        (clk),
        .rstN       (rstN),
        .pcStall    (pcStall),
        .stallCount (stallCount)
    );

endmodule

/* src/hazard_config.svh */
`ifndef HAZARD_CONFIG_SVH
`define HAZARD_CONFIG_SVH

// Instruction and data width
`define INSTR_W 16

// Register index width for eight registers
`define REG_W 3

// Register written by JAL and JALR
`define LINK_REG 7

// Width of the stall cycle counter
`define STALL_CNT_W 16

`endif

/* src/jumpControl.sv */
`timescale 1ns/1ps
`include "hazard_config.svh"

module jumpControl import hazardPkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  logic [`INSTR_W-1:0] instr,
    input  logic                regHaz,
    input  logic                memHaz,
    output logic                link,
    output logic                rsOnly,
    output logic                nop,
    output logic                pcStall
);

    jumpStateT           state;
    logic [`INSTR_W-1:0] prevInstr;
    opcodeT              op;
    logic                isJump;
    logic                newInstr;
    logic                jumpStall;

    assign op = opcodeT'(instr[15:11]);

    // Jump decode
    always_comb begin
        isJump = 1'b0;
        link   = 1'b0;
        rsOnly = 1'b0;
        case (op)
            J: isJump = 1'b1;
            JR: begin
                isJump = 1'b1;
                rsOnly = 1'b1;
            end
            JAL: begin
                isJump = 1'b1;
                link   = 1'b1;
            end
            JALR: begin
                isJump = 1'b1;
                link   = 1'b1;
                rsOnly = 1'b1;
            end
            default: isJump = 1'b0;  // Branches in 011xx resolve outside
        endcase
    end

    assign newInstr  = (instr != prevInstr);
    assign jumpStall = (state == IDLE) & isJump & newInstr & ~regHaz & ~memHaz;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= IDLE;
            prevInstr <= '0;
        end else begin
            prevInstr <= instr;
            case (state)
                IDLE:    if (jumpStall) state <= HOLD;
                HOLD:    if (newInstr) state <= IDLE;  // Jump has left IF
                default: state <= IDLE;
            endcase
        end
    end

    assign nop     = regHaz | memHaz;
    assign pcStall = nop | jumpStall;

    nopStallsPc: assert property (
        @(posedge clk) disable iff (!rstN)
        nop |-> pcStall
    ) else $error("Bubble issued without PC stall");

endmodule

/* src/memHazardCheck.sv */
`timescale 1ns/1ps
`include "hazard_config.svh"

// Memory RAW check on effective addresses still in flight
module memHazardCheck import hazardPkg::*; (
    input  logic [`INSTR_W-1:0] reg1Data,
    input  logic [`INSTR_W-1:0] imm,
    input  logic                memEnable,
    input  logic                branchTaken,
    input  memTagT              memStages [4],
    output memTagT              memIns,
    output logic                memHaz
);

    logic [`INSTR_W-1:0] effAddr;
    logic [3:0]          addrHit;

    // Base plus offset, carry out dropped
    assign effAddr = reg1Data + imm;

    // Enable and address tested together per stage
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            addrHit[i] = memStages[i].en && (memStages[i].addr == effAddr);
        end
        if (branchTaken) begin
            addrHit[0] = 1'b0;  // ID access is being squashed
        end
    end

    assign memHaz = memEnable & (|addrHit);

    // Tag handed to the memory tracker
    assign memIns = '{
        addr: effAddr,
        en:   memEnable
    };

endmodule

/* src/regHazardCheck.sv */
`timescale 1ns/1ps
`include "hazard_config.svh"

module regHazardCheck import hazardPkg::*; (
    input  logic [`INSTR_W-1:0] instr,
    input  logic [`REG_W-1:0]   rd,
    input  logic                regWrite,
    input  logic                link,
    input  logic                rsOnly,
    input  logic                branchTaken,
    input  regTagT              regStages [4],
    output regTagT              regIns,
    output logic                regHaz,
    output logic [3:0]          forwards
);

    localparam logic [`REG_W-1:0] LINK_RD = `LINK_REG;

    logic [`REG_W-1:0] rs;
    logic [`REG_W-1:0] rt;
    logic [3:0]        rsHit;
    logic [3:0]        rtHit;

    assign rs = instr[10:8];
    assign rt = instr[7:5];

    // Per stage source match against live writers
    always_comb begin
        logic live;
        for (int i = 0; i < 4; i++) begin
            live = regStages[i].wr && !(i == 0 && branchTaken);  // ID writer squashed
            rsHit[i] = live && (regStages[i].rd == rs);
            rtHit[i] = live && (regStages[i].rd == rt);
        end
    end

    // JR and JALR read rs only
    assign regHaz = (|rsHit) | (~rsOnly & (|rtHit));

    // Order exRs, memRs, exRt, memRt
    // ID entry feeds the EX to EX path, EX entry the MEM to EX path
    assign forwards = {rsHit[0], rsHit[1], rtHit[0], rtHit[1]};

    // Link jumps always write the link register
    assign regIns = '{
        rd: link ? LINK_RD : rd,
        wr: regWrite | link
    };

endmodule

/* src/stageTrack.sv */
`timescale 1ns/1ps

// Tracks one tag per instruction for the four stages ahead of IF
// stages[0] is ID, then EX, MEM and WB
module stageTrack #(
    parameter type tagT = logic
) (
    input  logic clk,
    input  logic rstN,
    input  tagT  insTag,
    input  logic bubble,
    input  logic flush,
    output tagT  stages [4]
);

    localparam tagT EMPTY = tagT'('0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 4; i++) begin
                stages[i] <= EMPTY;
            end
        end else begin
            stages[0] <= bubble ? EMPTY : insTag;    // Bubble enters ID as an empty slot
            stages[1] <= flush ? EMPTY : stages[0];  // Squashed ID instruction never reaches EX
            for (int i = 2; i < 4; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    // A squashed instruction must leave no trace in EX
    flushClearsEx: assert property (
        @(posedge clk) disable iff (!rstN)
        flush |=> (stages[1] == EMPTY)
    ) else $error("EX entry not cleared after flush");

endmodule

/* src/stallTimer.sv */
`timescale 1ns/1ps
`include "hazard_config.svh"

// Performance counter of PC stall cycles
module stallTimer (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    pcStall,
    output logic [`STALL_CNT_W-1:0] stallCount
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stallCount <= '0;
        end else if (pcStall && (stallCount != '1)) begin
            stallCount <= stallCount + 1'b1;  // Holds at all ones
        end
    end

    countMonotonic: assert property (
        @(posedge clk) disable iff (!rstN)
        $past(rstN) |-> (stallCount >= $past(stallCount))
    ) else $error("Stall count went backwards");

endmodule

/* test/hazardUnitTb.sv */
`timescale 1ns/1ps
`include "hazard_config.svh"

module hazardUnitTb;

    localparam logic [4:0] opNop  = 5'b00001;
    localparam logic [4:0] opAlu  = 5'b00010;
    localparam logic [4:0] opLoad = 5'b10000;
    localparam logic [4:0] opJ    = 5'b00100;
    localparam logic [4:0] opJr   = 5'b00101;
    localparam logic [4:0] opJal  = 5'b00110;
    localparam logic [4:0] opJalr = 5'b00111;
    localparam logic [`REG_W-1:0] linkRd = `LINK_REG;

    // Each slot costs at most about six cycles with stalls and the jump bubble
    localparam int directedSlots = 30;
    localparam int randomSlots   = 120;
    localparam int timeoutCycles = 100 + (directedSlots + randomSlots) * 6;

    logic clk = 1'b0;
    logic rstN = 1'b0;
    logic [`INSTR_W-1:0] instr = '0;
    logic [`REG_W-1:0] rd = '0;
    logic regWrite = 1'b0;
    logic memEnable = 1'b0;
    logic [`INSTR_W-1:0] reg1Data = '0;
    logic [`INSTR_W-1:0] imm = '0;
    logic branchTaken = 1'b0;
    logic nop;
    logic pcStall;
    logic [3:0] forwards;
    logic [`STALL_CNT_W-1:0] stallCount;

    // Shadow history with index 0 as ID
    logic [`REG_W-1:0] histRd [4];
    logic histWr [4];
    logic [`INSTR_W-1:0] histAddr [4];
    logic histEn [4];
    logic [`INSTR_W-1:0] lastInstr;
    logic holding;  // Jump already bubbled
    logic [`STALL_CNT_W-1:0] expCount;

    logic isJump;
    logic rsOnlyExp;
    logic linkExp;
    logic [`INSTR_W-1:0] effAddr;
    logic expRegHaz;
    logic expMemHaz;
    logic [3:0] expFwd;
    logic expNop;
    logic expJumpStall;
    logic expPcStall;
    int cycleCount = 0;

    hazardUnit hazardUnit_i (
        .clk(clk), .rstN(rstN), .instr(instr), .rd(rd), .regWrite(regWrite),
        .memEnable(memEnable), .reg1Data(reg1Data), .imm(imm), .branchTaken(branchTaken),
        .nop(nop), .pcStall(pcStall), .forwards(forwards), .stallCount(stallCount)
    );

    always #50 clk = ~clk;

    assign isJump    = (instr[15:13] == 3'b001);  // J, JR, JAL, JALR
    assign rsOnlyExp = isJump && instr[11];
    assign linkExp   = isJump && instr[12];
    assign effAddr   = reg1Data + imm;

    always_comb begin
        expRegHaz = 1'b0;
        expMemHaz = 1'b0;
        expFwd = '0;
        for (int s = 0; s < 4; s++) begin
            if (!(s == 0 && branchTaken)) begin
                if (histWr[s] && histRd[s] == instr[10:8]) begin
                    expRegHaz = 1'b1;
                    if (s < 2) expFwd[3 - s] = 1'b1;  // exRs from ID, memRs from EX
                end
                if (histWr[s] && histRd[s] == instr[7:5]) begin
                    expRegHaz = expRegHaz | !rsOnlyExp;
                    if (s < 2) expFwd[1 - s] = 1'b1;
                end
                if (memEnable && histEn[s] && histAddr[s] == effAddr) expMemHaz = 1'b1;
            end
        end
    end

    assign expNop       = expRegHaz | expMemHaz;
    assign expJumpStall = !holding && isJump && (instr != lastInstr) && !expNop;
    assign expPcStall   = expNop | expJumpStall;

    always @(posedge clk) begin
        if (!rstN) begin
            for (int s = 0; s < 4; s++) begin
                histRd[s] <= '0;
                histWr[s] <= 1'b0;
                histAddr[s] <= '0;
                histEn[s] <= 1'b0;
            end
            lastInstr <= '0;
            holding <= 1'b0;
            expCount <= '0;
        end else begin
            histRd[0]   <= expNop ? '0 : (linkExp ? linkRd : rd);
            histWr[0]   <= !expNop && (regWrite || linkExp);
            histAddr[0] <= expNop ? '0 : effAddr;
            histEn[0]   <= !expNop && memEnable;
            histRd[1]   <= branchTaken ? '0 : histRd[0];  // Squashed ID entry
            histWr[1]   <= !branchTaken && histWr[0];
            histAddr[1] <= branchTaken ? '0 : histAddr[0];
            histEn[1]   <= !branchTaken && histEn[0];
            for (int s = 2; s < 4; s++) begin
                histRd[s] <= histRd[s-1];
                histWr[s] <= histWr[s-1];
                histAddr[s] <= histAddr[s-1];
                histEn[s] <= histEn[s-1];
            end
            lastInstr <= instr;
            if (expJumpStall) holding <= 1'b1;
            else if (instr != lastInstr) holding <= 1'b0;
            if (expPcStall && expCount != '1) expCount <= expCount + 1'b1;
        end
    end

    task automatic reportMismatch(input string what);
        $display("Mismatch at %0t ns: %s", $time, what);
        $display("Something failed");
        $fatal(1, "Stopped at first error");
    endtask

    resetIdle: assert property (@(posedge clk) $rose(rstN) |->
        (!nop && !pcStall && forwards == 4'b0 && stallCount == '0))
        else reportMismatch("outputs not idle after reset");
    nopCheck: assert property (@(posedge clk) disable iff (!rstN) nop == expNop)
        else reportMismatch("nop differs from the tracked history");
    pcStallCheck: assert property (@(posedge clk) disable iff (!rstN) pcStall == expPcStall)
        else reportMismatch("pcStall differs from the jump and hazard rules");
    forwardsCheck: assert property (@(posedge clk) disable iff (!rstN) forwards == expFwd)
        else reportMismatch("forwards differ from ID and EX matches");
    countCheck: assert property (@(posedge clk) disable iff (!rstN) stallCount == expCount)
        else reportMismatch("stallCount differs from the stall cycles seen");

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout after %0d cycles, the stimulus did not complete", cycleCount);
            $display("Something failed");
            $fatal(1, "Timeout");
        end
    end

    function automatic logic [`INSTR_W-1:0] makeInstr(input logic [4:0] op,
            input logic [2:0] rs, input logic [2:0] rt, input logic [4:0] low);
        return {op, rs, rt, low};
    endfunction

    // One issued slot, held while the PC is stalled
    task automatic issue(input logic [`INSTR_W-1:0] word, input logic [2:0] dest,
            input logic wr, input logic mem, input logic [`INSTR_W-1:0] base,
            input logic [`INSTR_W-1:0] offset, input logic squash);
        @(posedge clk);
        instr <= word;
        rd <= dest;
        regWrite <= wr;
        memEnable <= mem;
        reg1Data <= base;
        imm <= offset;
        branchTaken <= squash;
        @(negedge clk);
        while (pcStall) begin
            @(posedge clk);
            branchTaken <= 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic idleSlot();
        issue(makeInstr(opNop, 3'd0, 3'd0, 5'd0), 3'd0, 1'b0, 1'b0, '0, '0, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h9206));
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        repeat (2) idleSlot();
        // Register RAW on rs and on rt, then an unrelated reader
        issue(makeInstr(opAlu, 3'd1, 3'd2, 5'd0), 3'd3, 1'b1, 1'b0, '0, '0, 1'b0);
        issue(makeInstr(opAlu, 3'd3, 3'd0, 5'd1), 3'd4, 1'b1, 1'b0, '0, '0, 1'b0);
        idleSlot();
        issue(makeInstr(opAlu, 3'd0, 3'd4, 5'd2), 3'd5, 1'b1, 1'b0, '0, '0, 1'b0);
        issue(makeInstr(opAlu, 3'd6, 3'd6, 5'd3), 3'd1, 1'b0, 1'b0, '0, '0, 1'b0);
        // JR reads rs only
        issue(makeInstr(opAlu, 3'd0, 3'd0, 5'd4), 3'd2, 1'b1, 1'b0, '0, '0, 1'b0);
        issue(makeInstr(opJr, 3'd6, 3'd2, 5'd0), 3'd0, 1'b0, 1'b0, '0, '0, 1'b0);
        // Squashed writer never hazards
        issue(makeInstr(opAlu, 3'd1, 3'd1, 5'd5), 3'd6, 1'b1, 1'b0, '0, '0, 1'b0);
        issue(makeInstr(opAlu, 3'd6, 3'd0, 5'd6), 3'd0, 1'b0, 1'b0, '0, '0, 1'b1);
        issue(makeInstr(opAlu, 3'd6, 3'd6, 5'd7), 3'd0, 1'b0, 1'b0, '0, '0, 1'b0);
        // Memory RAW with address wraparound, then distinct addresses
        issue(makeInstr(opLoad, 3'd0, 3'd0, 5'd0), 3'd0, 1'b0, 1'b1, 16'hFFF0, 16'h0020, 1'b0);
        issue(makeInstr(opLoad, 3'd0, 3'd0, 5'd1), 3'd0, 1'b0, 1'b1, 16'h0008, 16'h0008, 1'b0);
        issue(makeInstr(opLoad, 3'd0, 3'd0, 5'd2), 3'd0, 1'b0, 1'b1, 16'h1000, 16'h0000, 1'b0);
        issue(makeInstr(opLoad, 3'd0, 3'd0, 5'd3), 3'd0, 1'b0, 1'b1, 16'h2000, 16'h0004, 1'b0);
        // Each jump kind, the same J twice, and a reader of the link register
        issue(makeInstr(opJ, 3'd0, 3'd0, 5'd9), 3'd0, 1'b0, 1'b0, '0, '0, 1'b0);
        issue(makeInstr(opJ, 3'd0, 3'd0, 5'd9), 3'd0, 1'b0, 1'b0, '0, '0, 1'b0);
        issue(makeInstr(opJr, 3'd1, 3'd0, 5'd0), 3'd0, 1'b0, 1'b0, '0, '0, 1'b0);
        issue(makeInstr(opJal, 3'd0, 3'd0, 5'd0), 3'd0, 1'b0, 1'b0, '0, '0, 1'b0);
        issue(makeInstr(opAlu, 3'd7, 3'd0, 5'd0), 3'd1, 1'b1, 1'b0, '0, '0, 1'b0);
        issue(makeInstr(opJalr, 3'd5, 3'd3, 5'd0), 3'd0, 1'b0, 1'b0, '0, '0, 1'b0);
        repeat (3) idleSlot();
        repeat (randomSlots) begin
            issue(makeInstr(5'($urandom_range(7, 0)), 3'($urandom_range(7, 0)),
                      3'($urandom_range(7, 0)), 5'($urandom_range(3, 0))),
                  3'($urandom_range(7, 0)), 1'($urandom_range(1, 0)),
                  1'($urandom_range(1, 0)), 16'($urandom_range(7, 0)),
                  16'($urandom_range(3, 0)), ($urandom_range(7, 0) == 0));
        end
        repeat (4) idleSlot();
        $display("Everything OK");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+src
src/hazardPkg.sv
src/stageTrack.sv
src/regHazardCheck.sv
src/memHazardCheck.sv
src/jumpControl.sv
src/stallTimer.sv
src/hazardUnit.sv
test/hazardUnitTb.sv
